//--- hw/matrix_pkg.sv
`default_nettype none

package matrix_pkg;

    localparam int MAX_DIM   = 5;
    localparam int NUM_SLOTS = 4;
    localparam int MAX_ELEM  = 9;

    typedef logic [15:0] elem_t;
    typedef logic [2:0]  idx_t;   // Row, column or dimension
    typedef logic [1:0]  slot_t;

    // Loader to store
    typedef struct packed {
        slot_t slot;
        idx_t  row;
        idx_t  col;
        elem_t data;
        logic  we;
    } elem_wr_t;

    typedef struct packed {
        slot_t slot;
        idx_t  m;
        idx_t  n;
        logic  we;
    } dim_wr_t;

    // Printer to store and back
    typedef struct packed {
        slot_t slot;
        idx_t  row;
        idx_t  col;
    } elem_rd_t;

    typedef struct packed {
        idx_t m;
        idx_t n;
    } dim_t;

endpackage

`default_nettype wire

//--- hw/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // 100 MHz clock, 115200 baud
    localparam int CLKS_PER_BIT = 868;
    localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

    typedef logic [7:0] byte_t;

    // ----------------------------------------
    // Character codes
    // ----------------------------------------
    localparam byte_t ASCII_LBRACKET = 8'h5B;
    localparam byte_t ASCII_RBRACKET = 8'h5D;
    localparam byte_t ASCII_SPACE    = 8'h20;
    localparam byte_t ASCII_NEWLINE  = 8'h0A;
    localparam byte_t ASCII_ZERO     = 8'h30;
    localparam byte_t ASCII_COMMA    = 8'h2C;
    localparam byte_t ASCII_CR       = 8'h0D;

endpackage

`default_nettype wire

//--- hw/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            rxd,
    output uart_pkg::byte_t rx_byte,
    output logic            rx_valid
);
    import uart_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t             state;
    logic [1:0]            rxd_sync;
    logic                  rxd_s;
    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic [2:0]            bit_idx;
    logic                  bit_end;
    byte_t                 shift;

    assign rxd_s   = rxd_sync[1];
    assign bit_end = (baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1));
    assign rx_byte = shift;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_sync <= 2'b11;   // Line idles high
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (!rxd_s) state <= RX_START;
                end
                RX_START: begin
                    // Half a bit in, recheck the start bit
                    if (baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rxd_s ? RX_IDLE : RX_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        rx_valid <= rxd_s;   // Framing error drops the byte
                        state    <= RX_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) shift <= {rxd_s, shift[7:1]};
    end

endmodule

`default_nettype wire

//--- hw/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic            clk,
    input  logic            rst_n,
    input  uart_pkg::byte_t tx_byte,
    input  logic            tx_start,
    output logic            txd,
    output logic            tx_ready
);
    import uart_pkg::*;

    logic                  busy;
    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic [3:0]            bit_cnt;
    logic                  bit_end;
    logic [9:0]            frame;   // Stop, data, start

    assign bit_end  = (baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1));
    assign tx_ready = !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            txd      <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy) begin
            txd      <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            if (tx_start) begin
                busy <= 1'b1;
                txd  <= 1'b0;   // Start bit
            end
        end else if (bit_end) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;   // Stop bit done
                txd  <= 1'b1;
            end else begin
                txd <= frame[1];
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && tx_start) frame <= {1'b1, tx_byte, 1'b0};
        else if (busy && bit_end) frame <= {1'b1, frame[9:1]};
    end

endmodule

`default_nettype wire

//--- hw/number_parser.sv
`timescale 1ns/1ps
`default_nettype none

module number_parser (
    input  logic              clk,
    input  logic              rst_n,
    input  uart_pkg::byte_t   rx_byte,
    input  logic              rx_valid,
    output matrix_pkg::elem_t num,
    output logic              num_valid
);
    import uart_pkg::*;
    import matrix_pkg::*;

    elem_t acc;
    logic  have_digit;   // Digit seen since last separator
    byte_t digit;
    logic  is_digit;
    logic  is_sep;

    // Characters below '0' wrap to large values
    assign digit    = rx_byte - ASCII_ZERO;
    assign is_digit = (digit <= 8'd9);
    assign is_sep   = (rx_byte == ASCII_SPACE) || (rx_byte == ASCII_COMMA) ||
                      (rx_byte == ASCII_CR)    || (rx_byte == ASCII_NEWLINE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc        <= '0;
            have_digit <= 1'b0;
            num        <= '0;
            num_valid  <= 1'b0;
        end else begin
            num_valid <= 1'b0;
            if (rx_valid) begin
                if (is_digit) begin
                    acc        <= elem_t'(acc * 16'd10) + {8'd0, digit};
                    have_digit <= 1'b1;
                end else if (is_sep && have_digit) begin
                    num        <= acc;
                    num_valid  <= 1'b1;
                    acc        <= '0;
                    have_digit <= 1'b0;
                end else begin
                    // Repeated separator or junk character
                    acc        <= '0;
                    have_digit <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/matrix_loader.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_loader (
    input  logic                 clk,
    input  logic                 rst_n,
    input  matrix_pkg::elem_t    num,
    input  logic                 num_valid,
    input  matrix_pkg::slot_t    slot_sel,
    output matrix_pkg::elem_wr_t elem_wr,
    output matrix_pkg::dim_wr_t  dim_wr,
    output logic                 load_done,
    output logic                 input_error
);
    import matrix_pkg::*;

    typedef enum logic [1:0] {LD_WAIT_M, LD_WAIT_N, LD_FILL} ld_state_t;

    ld_state_t state;
    slot_t     slot;
    idx_t      dim_m;
    idx_t      dim_n;
    idx_t      row;
    idx_t      col;
    logic      dim_ok;
    logic      elem_ok;
    logic      last_row;
    logic      last_col;

    assign dim_ok   = (num >= 16'd1) && (num <= 16'(MAX_DIM));
    assign elem_ok  = (num <= 16'(MAX_ELEM));
    assign last_row = (row == dim_m - 3'd1);
    assign last_col = (col == dim_n - 3'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= LD_WAIT_M;
            slot        <= '0;
            dim_m       <= '0;
            dim_n       <= '0;
            row         <= '0;
            col         <= '0;
            elem_wr     <= '0;
            dim_wr      <= '0;
            load_done   <= 1'b0;
            input_error <= 1'b0;
        end else begin
            elem_wr.we  <= 1'b0;
            dim_wr.we   <= 1'b0;
            load_done   <= 1'b0;
            input_error <= 1'b0;
            if (num_valid) begin
                case (state)
                    LD_WAIT_M: begin
                        if (dim_ok) begin
                            dim_m <= idx_t'(num);
                            slot  <= slot_sel;   // Slot fixed for the whole load
                            state <= LD_WAIT_N;
                        end else begin
                            input_error <= 1'b1;
                        end
                    end
                    LD_WAIT_N: begin
                        if (dim_ok) begin
                            dim_n  <= idx_t'(num);
                            dim_wr <= '{slot: slot, m: dim_m, n: idx_t'(num), we: 1'b1};
                            row    <= '0;
                            col    <= '0;
                            state  <= LD_FILL;
                        end else begin
                            input_error <= 1'b1;
                        end
                    end
                    default: begin
                        if (elem_ok) begin
                            elem_wr <= '{slot: slot, row: row, col: col, data: num, we: 1'b1};
                            if (last_col) begin
                                col <= '0;
                                row <= row + 3'd1;
                                if (last_row) begin
                                    load_done <= 1'b1;   // Same cycle as last write
                                    state     <= LD_WAIT_M;
                                end
                            end else begin
                                col <= col + 3'd1;
                            end
                        end else begin
                            input_error <= 1'b1;   // Skipped, not counted
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/matrix_store.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_store (
    input  logic                 clk,
    input  logic                 rst_n,
    input  matrix_pkg::elem_wr_t elem_wr,
    input  matrix_pkg::dim_wr_t  dim_wr,
    input  matrix_pkg::elem_rd_t rd_addr,
    output matrix_pkg::elem_t    rd_data,
    output matrix_pkg::dim_t     rd_dim
);
    import matrix_pkg::*;

    elem_t mem [NUM_SLOTS][MAX_DIM][MAX_DIM];
    dim_t  dims [NUM_SLOTS];

    // ----------------------------------------
    // Element array, registered read
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (elem_wr.we) begin
            mem[elem_wr.slot][elem_wr.row][elem_wr.col] <= elem_wr.data;
        end
        rd_data <= mem[rd_addr.slot][rd_addr.row][rd_addr.col];
    end

    // ----------------------------------------
    // Per-slot dimensions
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                dims[i] <= '0;   // m of zero marks an empty slot
            end
        end else if (dim_wr.we) begin
            dims[dim_wr.slot] <= '{m: dim_wr.m, n: dim_wr.n};
        end
    end

    assign rd_dim = dims[rd_addr.slot];

endmodule

`default_nettype wire

//--- hw/matrix_printer.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_printer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 print_req,
    input  matrix_pkg::slot_t    slot_sel,
    output matrix_pkg::elem_rd_t rd_addr,
    input  matrix_pkg::elem_t    rd_data,
    input  matrix_pkg::dim_t     rd_dim,
    output uart_pkg::byte_t      tx_byte,
    output logic                 tx_start,
    input  logic                 tx_ready,
    output logic                 print_busy
);
    import matrix_pkg::*;
    import uart_pkg::*;

    typedef enum logic [3:0] {
        P_IDLE, P_OPEN, P_READ, P_LATCH, P_DIGIT,
        P_SEP, P_ROW_END, P_CLOSE, P_FINAL_NL, P_DRAIN
    } pr_state_t;

    pr_state_t state;
    slot_t     slot;
    idx_t      row;
    idx_t      col;
    byte_t     digit_char;
    logic      can_send;
    logic      last_row;
    logic      last_col;

    // tx_ready lags tx_start by one cycle
    assign can_send = tx_ready && !tx_start;
    assign last_row = (row == rd_dim.m - 3'd1);
    assign last_col = (col == rd_dim.n - 3'd1);
    assign rd_addr  = '{slot: slot, row: row, col: col};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= P_IDLE;
            slot       <= '0;
            row        <= '0;
            col        <= '0;
            digit_char <= '0;
            tx_byte    <= '0;
            tx_start   <= 1'b0;
            print_busy <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (state)
                P_IDLE: begin
                    if (print_req) begin
                        slot       <= slot_sel;
                        row        <= '0;
                        col        <= '0;
                        print_busy <= 1'b1;
                        state      <= P_OPEN;
                    end
                end
                P_OPEN: begin
                    if (can_send) begin
                        tx_byte  <= ASCII_LBRACKET;
                        tx_start <= 1'b1;
                        state    <= (rd_dim.m == '0) ? P_CLOSE : P_READ;   // Empty slot
                    end
                end
                P_READ:  state <= P_LATCH;   // Store read takes a cycle
                P_LATCH: begin
                    digit_char <= ASCII_ZERO + rd_data[7:0];
                    state      <= P_DIGIT;
                end
                P_DIGIT: begin
                    if (can_send) begin
                        tx_byte  <= digit_char;
                        tx_start <= 1'b1;
                        state    <= last_col ? P_ROW_END : P_SEP;
                    end
                end
                P_SEP: begin
                    if (can_send) begin
                        tx_byte  <= ASCII_SPACE;
                        tx_start <= 1'b1;
                        col      <= col + 3'd1;
                        state    <= P_READ;
                    end
                end
                P_ROW_END: begin
                    if (last_row) begin
                        state <= P_CLOSE;
                    end else if (can_send) begin
                        tx_byte  <= ASCII_NEWLINE;
                        tx_start <= 1'b1;
                        row      <= row + 3'd1;
                        col      <= '0;
                        state    <= P_READ;
                    end
                end
                P_CLOSE: begin
                    if (can_send) begin
                        tx_byte  <= ASCII_RBRACKET;
                        tx_start <= 1'b1;
                        state    <= P_FINAL_NL;
                    end
                end
                P_FINAL_NL: begin
                    if (can_send) begin
                        tx_byte  <= ASCII_NEWLINE;
                        tx_start <= 1'b1;
                        state    <= P_DRAIN;
                    end
                end
                default: begin
                    // Hold busy until the last stop bit is out
                    if (can_send) begin
                        print_busy <= 1'b0;
                        state      <= P_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/matrix_term_top.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_term_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              uart_rxd,
    output logic              uart_txd,
    input  matrix_pkg::slot_t slot_sel,
    input  logic              print_req,
    output logic              load_done,
    output logic              input_error,
    output logic              print_busy
);
    import matrix_pkg::*;
    import uart_pkg::*;

    byte_t    rx_byte;
    logic     rx_valid;
    elem_t    num;
    logic     num_valid;
    elem_wr_t elem_wr;
    dim_wr_t  dim_wr;
    elem_rd_t rd_addr;
    elem_t    rd_data;
    dim_t     rd_dim;
    byte_t    tx_byte;
    logic     tx_start;
    logic     tx_ready;

    // ----------------------------------------
    // Serial in to memory
    // ----------------------------------------
    uart_rx u_rx (
        .clk(clk), .rst_n(rst_n), .rxd(uart_rxd),
        .rx_byte(rx_byte), .rx_valid(rx_valid)
    );

    number_parser u_parser (
        .clk(clk), .rst_n(rst_n), .rx_byte(rx_byte), .rx_valid(rx_valid),
        .num(num), .num_valid(num_valid)
    );

    matrix_loader u_loader (
        .clk(clk), .rst_n(rst_n), .num(num), .num_valid(num_valid),
        .slot_sel(slot_sel), .elem_wr(elem_wr), .dim_wr(dim_wr),
        .load_done(load_done), .input_error(input_error)
    );

    matrix_store u_store (
        .clk(clk), .rst_n(rst_n), .elem_wr(elem_wr), .dim_wr(dim_wr),
        .rd_addr(rd_addr), .rd_data(rd_data), .rd_dim(rd_dim)
    );

    // ----------------------------------------
    // Memory to serial out
    // ----------------------------------------
    matrix_printer u_printer (
        .clk(clk), .rst_n(rst_n), .print_req(print_req), .slot_sel(slot_sel),
        .rd_addr(rd_addr), .rd_data(rd_data), .rd_dim(rd_dim),
        .tx_byte(tx_byte), .tx_start(tx_start), .tx_ready(tx_ready),
        .print_busy(print_busy)
    );

    uart_tx u_tx (
        .clk(clk), .rst_n(rst_n), .tx_byte(tx_byte), .tx_start(tx_start),
        .txd(uart_txd), .tx_ready(tx_ready)
    );

endmodule

`default_nettype wire

//--- verification/tb_uart_bfm.svh
`ifndef TB_UART_BFM_SVH
`define TB_UART_BFM_SVH

// ----------------------------------------
// Serial line tasks, 8N1, LSB first
// ----------------------------------------
task automatic send_text(input string text);
    logic [9:0] frame;
    @(posedge clk);
    for (int i = 0; i < text.len(); i++) begin
        frame = {1'b1, text[i], 1'b0};   // Stop, data, start
        for (int b = 0; b < 10; b++) begin
            uart_rxd <= frame[b];
            repeat (CLKS_PER_BIT) @(posedge clk);
        end
    end
endtask

// Collects characters until a newline follows a closing bracket
task automatic recv_text(input string name, output string text);
    byte_t ch;
    byte_t prev;
    int    waited;
    bit    done;
    text = "";
    prev = 8'h00;
    done = 1'b0;
    while (!done) begin
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (uart_txd !== 1'b0 && waited < CHAR_TIMEOUT);
        assert (uart_txd === 1'b0) else begin
            $display("%s: timed out waiting for a start bit on uart_txd", name);
            fail_cnt++;
        end
        if (uart_txd !== 1'b0) begin
            done = 1'b1;
        end else begin
            repeat (CLKS_PER_BIT / 2) @(negedge clk);   // Middle of start bit
            for (int b = 0; b < 8; b++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                ch[b] = uart_txd;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            assert (uart_txd === 1'b1) else begin
                $display("%s: stop bit was low on uart_txd", name);
                fail_cnt++;
            end
            text = $sformatf("%s%c", text, ch);
            done = (prev == ASCII_RBRACKET && ch == ASCII_NEWLINE) || text.len() >= MAX_CHARS;
            prev = ch;
        end
    end
endtask

// Waits until a pulse counter reaches its target
task automatic wait_flag(input string name, input int id, input int target, input string what);
    int waited;
    waited = 0;
    while (flag_count(id) < target && waited < FLAG_TIMEOUT) begin
        @(posedge clk);
        waited++;
    end
    assert (flag_count(id) >= target) else begin
        $display("%s: timed out waiting for %s", name, what);
        fail_cnt++;
    end
endtask

`endif

//--- verification/tb_matrix_term.sv
`timescale 1ns/1ps
`default_nettype none

module tb_matrix_term;
    import matrix_pkg::*;
    import uart_pkg::*;

    localparam int FLAG_TIMEOUT = 4 * CLKS_PER_BIT;
    localparam int CHAR_TIMEOUT = 20 * CLKS_PER_BIT;
    localparam int MAX_CHARS    = 128;
    localparam int FLAG_LOAD    = 0;
    localparam int FLAG_ERR     = 1;
    localparam int FLAG_IDLE    = 2;   // Falling edges of print_busy

    logic  clk;
    logic  rst_n;
    logic  uart_rxd;
    logic  uart_txd;
    slot_t slot_sel;
    logic  print_req;
    logic  load_done;
    logic  input_error;
    logic  print_busy;

    int   fail_cnt;
    int   check_cnt;
    int   load_cnt;
    int   err_cnt;
    int   idle_cnt;
    logic busy_q;

    matrix_term_top uut (
        .clk(clk), .rst_n(rst_n), .uart_rxd(uart_rxd), .uart_txd(uart_txd),
        .slot_sel(slot_sel), .print_req(print_req), .load_done(load_done),
        .input_error(input_error), .print_busy(print_busy)
    );

    always #4 clk = ~clk;

    // Pulse counters, updated on the falling edge
    always @(negedge clk) begin
        if (load_done) load_cnt++;
        if (input_error) err_cnt++;
        if (busy_q && !print_busy) idle_cnt++;
        busy_q = print_busy;
    end

    function automatic int flag_count(input int id);
        case (id)
            FLAG_LOAD: return load_cnt;
            FLAG_ERR:  return err_cnt;
            default:   return idle_cnt;
        endcase
    endfunction

    `include "tb_uart_bfm.svh"

    // Newlines and CRs made visible for error lines
    function automatic string show_text(input string s);
        string r;
        r = "";
        for (int i = 0; i < s.len(); i++) begin
            if (s[i] == ASCII_NEWLINE) r = $sformatf("%s\\n", r);
            else if (s[i] == ASCII_CR) r = $sformatf("%s\\r", r);
            else r = $sformatf("%s%c", r, s[i]);
        end
        return r;
    endfunction

    // ----------------------------------------
    // Checks and helpers
    // ----------------------------------------
    task automatic check_text(input string name, input string exp, input string got);
        check_cnt++;
        assert (got == exp) else begin
            $display("error %s: expected \"%s\" actual \"%s\"", name, show_text(exp),
                     show_text(got));
            fail_cnt++;
        end
    endtask

    task automatic check_count(input string name, input string what, input int exp,
                               input int got);
        check_cnt++;
        assert (got == exp) else begin
            $display("error %s: %s expected %0d actual %0d", name, what, exp, got);
            fail_cnt++;
        end
    endtask

    task automatic pulse_print(input slot_t slot);
        @(posedge clk);
        slot_sel  <= slot;
        print_req <= 1'b1;
        @(posedge clk);
        print_req <= 1'b0;
    endtask

    task automatic load_text(input slot_t slot, input string text);
        @(posedge clk);
        slot_sel <= slot;
        send_text(text);
    endtask

    // Prints one slot; extra_req fires a second request mid-print
    task automatic print_slot(input string name, input slot_t slot, input string exp,
                              input bit extra_req);
        string got;
        int    idle_before;
        idle_before = idle_cnt;
        pulse_print(slot);
        fork
            recv_text(name, got);
            begin
                if (extra_req) begin
                    repeat (3 * CLKS_PER_BIT) @(posedge clk);
                    pulse_print(~slot);
                end
            end
        join
        check_text(name, exp, got);
        wait_flag(name, FLAG_IDLE, idle_before + 1, "print_busy to fall");
        if (extra_req) begin
            repeat (2 * CLKS_PER_BIT) @(posedge clk);
            check_count(name, "print_busy after ignored request", 0, print_busy);
        end
    endtask

    task automatic make_matrix(output string text, output string exp);
        int m;
        int n;
        int v;
        m = $urandom % MAX_DIM + 1;
        n = $urandom % MAX_DIM + 1;
        text = $sformatf("%0d,%0d%c", m, n, ASCII_CR);
        exp  = "[";
        for (int r = 0; r < m; r++) begin
            for (int c = 0; c < n; c++) begin
                v    = $urandom % (MAX_ELEM + 1);
                text = $sformatf("%s%0d%c", text, v, ($urandom % 2) ? ASCII_COMMA : ASCII_CR);
                exp  = $sformatf("%s%0d", exp, v);
                if (c < n - 1) exp = $sformatf("%s ", exp);
                else if (r < m - 1) exp = $sformatf("%s\n", exp);
            end
        end
        exp = $sformatf("%s]\n", exp);
    endtask

    task automatic report(input string name, input int fails_before);
        $display("%-14s %s, %0d failed checks", name,
                 (fail_cnt == fails_before) ? "pass" : "FAIL", fail_cnt - fails_before);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_load_print();
        int fails_before;
        int loads_before;
        fails_before = fail_cnt;
        loads_before = load_cnt;
        load_text(2'd1, "2 3 1 2 3 4 5 6\n");
        wait_flag("load_print", FLAG_LOAD, loads_before + 1, "load_done");
        print_slot("load_print", 2'd1, "[1 2 3\n4 5 6]\n", 1'b0);
        report("load_print", fails_before);
    endtask

    task automatic test_bad_dims();
        int fails_before;
        int errs_before;
        int loads_before;
        fails_before = fail_cnt;
        errs_before  = err_cnt;
        load_text(2'd0, "6 ");
        wait_flag("bad_dims", FLAG_ERR, errs_before + 1, "input_error on dimension 6");
        load_text(2'd0, "0 ");
        wait_flag("bad_dims", FLAG_ERR, errs_before + 2, "input_error on dimension 0");
        loads_before = load_cnt;
        load_text(2'd0, "1 1 7\n");
        wait_flag("bad_dims", FLAG_LOAD, loads_before + 1, "load_done");
        check_count("bad_dims", "input_error pulses", errs_before + 2, err_cnt);
        print_slot("bad_dims", 2'd0, "[7]\n", 1'b0);
        report("bad_dims", fails_before);
    endtask

    task automatic test_bad_elems();
        int fails_before;
        int errs_before;
        int loads_before;
        fails_before = fail_cnt;
        errs_before  = err_cnt;
        loads_before = load_cnt;
        load_text(2'd2, "2 2 12 40 3 4 5 6\n");
        wait_flag("bad_elems", FLAG_LOAD, loads_before + 1, "load_done");
        check_count("bad_elems", "input_error pulses", errs_before + 2, err_cnt);
        check_count("bad_elems", "load_done pulses", loads_before + 1, load_cnt);
        print_slot("bad_elems", 2'd2, "[3 4\n5 6]\n", 1'b0);
        report("bad_elems", fails_before);
    endtask

    task automatic test_empty_slot();
        int fails_before;
        fails_before = fail_cnt;
        print_slot("empty_slot", 2'd3, "[]\n", 1'b0);
        report("empty_slot", fails_before);
    endtask

    task automatic test_random_slots();
        string text0;
        string exp0;
        string text2;
        string exp2;
        int    fails_before;
        int    errs_before;
        int    loads_before;
        fails_before = fail_cnt;
        errs_before  = err_cnt;
        loads_before = load_cnt;
        make_matrix(text0, exp0);
        make_matrix(text2, exp2);
        load_text(2'd0, text0);
        wait_flag("random_slots", FLAG_LOAD, loads_before + 1, "load_done for slot 0");
        load_text(2'd2, text2);
        wait_flag("random_slots", FLAG_LOAD, loads_before + 2, "load_done for slot 2");
        check_count("random_slots", "input_error pulses", errs_before, err_cnt);
        print_slot("random_slots", 2'd0, exp0, 1'b1);
        print_slot("random_slots", 2'd2, exp2, 1'b1);
        report("random_slots", fails_before);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        uart_rxd  = 1'b1;   // Idle line
        slot_sel  = '0;
        print_req = 1'b0;
        fail_cnt  = 0;
        check_cnt = 0;
        load_cnt  = 0;
        err_cnt   = 0;
        idle_cnt  = 0;
        busy_q    = 1'b0;
        void'($urandom(35));
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        test_load_print();
        test_bad_dims();
        test_bad_elems();
        test_empty_slot();
        test_random_slots();
        $display("checks %0d, failed %0d", check_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verification
hw/matrix_pkg.sv
hw/uart_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/number_parser.sv
hw/matrix_loader.sv
hw/matrix_store.sv
hw/matrix_printer.sv
hw/matrix_term_top.sv
verification/tb_matrix_term.sv
